/* verilog/life_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// row engine sizes, generation count and read pipeline depth
// row, address and neighbor count types with the life rule counts
////////////////////////////////////////////////////////////////////////////
package life_pkg;

	////////////////////////////////////////////////////////////////////////////
	// engine sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int ROW_WIDTH    = 64;                  // cells per row
	localparam int MEM_DEPTH    = 32;                  // rows held in the row ram
	localparam int ADDR_BITS    = $clog2(MEM_DEPTH);   // 5 for 32 rows
	localparam int NUM_GENS     = 2;                   // generation stages per pass

	// edges from address sample to row capture
	// one for the address reg, one for the output reg
	localparam int READ_LATENCY = 2;

	////////////////////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [ROW_WIDTH-1:0] row_t;     // one bit per cell, bit 0 is column 0
	typedef logic [ADDR_BITS-1:0] addr_t;    // row address
	typedef logic [1:0]           col_count_t; // live cells in a 3-high column, 0..3
	typedef logic [3:0]           nbr_count_t; // live cells in 3x3 incl center, 0..9

	////////////////////////////////////////////////////////////////////////////
	// life rule on the 3x3 sum
	////////////////////////////////////////////////////////////////////////////

	// center counted in the sum, so
	// 3 -> alive whatever the center was (birth or 2 neighbors + self)
	// 4 -> alive only if center alive (3 neighbors + self)
	localparam nbr_count_t BIRTH_COUNT   = 4'd3;
	localparam nbr_count_t SURVIVE_COUNT = 4'd4;

endpackage

/* verilog/life_row_ram.sv */
////////////////////////////////////////////////////////////////////////////
// two-port row memory, registered address, write port and read data
// write data select between init rows and the final generation
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module life_row_ram (
	input  logic            clk,
	input  logic            reset,
	input  life_pkg::addr_t raddr,      // sampled with sh or ld
	input  life_pkg::addr_t waddr,      // sampled with we
	input  logic            we,
	input  logic            init,       // selects init_data over result
	input  life_pkg::row_t  init_data,
	input  life_pkg::row_t  result,     // last generation stage output
	output life_pkg::row_t  rdata
);
	import life_pkg::*;

	row_t  mem [MEM_DEPTH];   // row storage, contents undefined after reset

	addr_t raddr_q;           // read address reg
	addr_t waddr_q;           // write address reg
	logic  we_q;              // write enable reg
	row_t  wdata_q;           // selected write data

	////////////////////////////////////////////////////////////////////////////
	// input registers
	////////////////////////////////////////////////////////////////////////////

	// registered write enable
	always_ff @(posedge clk) begin
		if (reset) begin
			we_q <= 1'b0;
		end else begin
			we_q <= we;
		end
	end

	// read and write address regs, write data select
	always_ff @(posedge clk) begin
		raddr_q <= raddr;
		waddr_q <= waddr;
		wdata_q <= init ? init_data : result;   // init rows win when init is up
	end

	////////////////////////////////////////////////////////////////////////////
	// array and output register
	////////////////////////////////////////////////////////////////////////////

	// write lands one edge after we was sampled
	always_ff @(posedge clk) begin
		if (we_q) begin
			mem[waddr_q] <= wdata_q;
		end
	end

	// read of registered address, registered out
	// a write at the same edge is seen from the next read on
	always_ff @(posedge clk) begin
		rdata <= mem[raddr_q];
	end

endmodule

/* verilog/life_read_align.sv */
////////////////////////////////////////////////////////////////////////////
// sh and ld delay lines matched to the row ram read latency
// dout snapshot register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module life_read_align (
	input  logic           clk,
	input  logic           reset,
	input  logic           sh,         // shift strobe from host
	input  logic           ld,         // load strobe from host
	input  life_pkg::row_t rdata,      // row ram read data
	output logic           shift_en,   // global window shift enable
	output life_pkg::row_t dout        // last loaded row
);
	import life_pkg::*;

	logic [READ_LATENCY-1:0] sh_del;   // bit 0 is the newest strobe
	logic [READ_LATENCY-1:0] ld_del;

	////////////////////////////////////////////////////////////////////////////
	// strobe delay lines
	////////////////////////////////////////////////////////////////////////////

	// one bit per strobe in flight, so back to back strobes each get a slot
	always_ff @(posedge clk) begin
		if (reset) begin
			sh_del <= '0;
			ld_del <= '0;
		end else begin
			sh_del <= {sh_del[READ_LATENCY-2:0], sh};
			ld_del <= {ld_del[READ_LATENCY-2:0], ld};
		end
	end

	assign shift_en = sh_del[READ_LATENCY-1];   // rdata now holds the sh row

	////////////////////////////////////////////////////////////////////////////
	// dout snapshot
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			dout <= '0;
		end else if (ld_del[READ_LATENCY-1]) begin
			dout <= rdata;   // hold until the next ld comes out of the line
		end
	end

endmodule

/* verilog/life_gen_stage.sv */
////////////////////////////////////////////////////////////////////////////
// one life generation over a three row window, horizontal wrap
// column sums, 3x3 sums, rule and the result row register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module life_gen_stage (
	input  logic           clk,
	input  logic           reset,
	input  logic           shift_en,   // aligned shift from life_read_align
	input  life_pkg::row_t row_in,     // ram row or previous stage result
	output life_pkg::row_t result      // next generation of the middle row
);
	import life_pkg::*;

	row_t       top_row;               // oldest row in the window
	row_t       mid_row;               // row being evolved
	row_t       bot_row;               // newest row
	col_count_t col_cnt [ROW_WIDTH];   // per column, top + mid + bot
	nbr_count_t nbr_cnt [ROW_WIDTH];   // per cell, left + own + right columns
	row_t       next_row;              // rule output, comb

	////////////////////////////////////////////////////////////////////////////
	// neighbor counting
	////////////////////////////////////////////////////////////////////////////

	// vertical tally, shared by three cells in the row
	always_comb begin
		for (int c = 0; c < ROW_WIDTH; c++) begin
			col_cnt[c] = {1'b0, top_row[c]} + {1'b0, mid_row[c]} + {1'b0, bot_row[c]};
		end
	end

	// horizontal sum of three column tallies
	always_comb begin
		int lft;
		int rgt;
		for (int c = 0; c < ROW_WIDTH; c++) begin
			lft = (c == 0) ? ROW_WIDTH - 1 : c - 1;   // column 0 sees the last one
			rgt = (c == ROW_WIDTH - 1) ? 0 : c + 1;   // and the last sees column 0
			nbr_cnt[c] = {2'b00, col_cnt[lft]}
				+ {2'b00, col_cnt[c]}
				+ {2'b00, col_cnt[rgt]};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// rule
	////////////////////////////////////////////////////////////////////////////

	// count includes the center cell itself
	always_comb begin
		for (int c = 0; c < ROW_WIDTH; c++) begin
			next_row[c] = (nbr_cnt[c] == BIRTH_COUNT)
				|| ((nbr_cnt[c] == SURVIVE_COUNT) && mid_row[c]);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// window shift and result register
	////////////////////////////////////////////////////////////////////////////

	// result takes the rule on the window before this shift
	always_ff @(posedge clk) begin
		if (reset) begin
			top_row <= '0;
			mid_row <= '0;
			bot_row <= '0;
			result  <= '0;
		end else if (shift_en) begin
			result  <= next_row;
			top_row <= mid_row;   // window moves down one row
			mid_row <= bot_row;
			bot_row <= row_in;
		end
	end

endmodule

/* verilog/life_row_engine.sv */
////////////////////////////////////////////////////////////////////////////
// linear row at a time life engine, top level
// row ram, strobe aligner and the chain of generation stages
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module life_row_engine (
	input  logic            clk,
	input  logic            reset,
	input  life_pkg::addr_t raddr,      // row for sh or ld, host picks vertical order
	input  life_pkg::addr_t waddr,      // row for we
	input  logic            we,         // write back or init write
	input  logic            sh,         // push row raddr into the stage chain
	input  logic            ld,         // snapshot row raddr onto dout
	input  logic            init,       // write init_data instead of the result
	input  life_pkg::row_t  init_data,
	output life_pkg::row_t  dout
);
	import life_pkg::*;

	row_t rdata;                   // ram read data, two edges after raddr
	logic shift_en;                // delayed sh, same for every stage
	row_t stage_row [NUM_GENS];    // stage inputs
	row_t stage_res [NUM_GENS];    // stage results

	////////////////////////////////////////////////////////////////////////////
	// row memory and read alignment
	////////////////////////////////////////////////////////////////////////////

	life_row_ram u_ram (
		.clk       (clk),
		.reset     (reset),
		.raddr     (raddr),
		.waddr     (waddr),
		.we        (we),
		.init      (init),
		.init_data (init_data),
		.result    (stage_res[NUM_GENS-1]),   // write back of the last generation
		.rdata     (rdata)
	);

	life_read_align u_align (
		.clk      (clk),
		.reset    (reset),
		.sh       (sh),
		.ld       (ld),
		.rdata    (rdata),
		.shift_en (shift_en),
		.dout     (dout)
	);

	////////////////////////////////////////////////////////////////////////////
	// generation chain
	////////////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < NUM_GENS; g++) begin : gen_stage
		if (g == 0) begin : gen_first
			assign stage_row[g] = rdata;              // first stage fed from ram
		end else begin : gen_next
			assign stage_row[g] = stage_res[g-1];     // later ones from the stage before
		end

		life_gen_stage u_stage (
			.clk      (clk),
			.reset    (reset),
			.shift_en (shift_en),
			.row_in   (stage_row[g]),
			.result   (stage_res[g])
		);
	end

endmodule

/* verification/life_row_engine_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the row engine, seeded random rows and a row level model
// init and load, sweeps with wrap, known patterns, back to back strobes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module life_row_engine_tb;
	import life_pkg::*;

	localparam int SRC_ROWS  = 16;             // source rows, vertical wrap over these
	localparam int DST_BASE  = 16;             // write back area
	localparam int PUSHES    = SRC_ROWS + 7;   // rows pushed per sweep, wrap margin included
	localparam int SWEEP_STROBES = 3 * SRC_ROWS + PUSHES;            // init, we, ld, sh
	localparam int B2B_STROBES   = 3 * SRC_ROWS + PUSHES + PUSHES / 2;
	localparam int TOTAL_STROBES = 2 * MEM_DEPTH + 3 * SWEEP_STROBES + B2B_STROBES;
	localparam int CYCLE_LIMIT   = 6 * TOTAL_STROBES + 200;

	logic  clk;
	logic  reset;
	addr_t raddr;
	addr_t waddr;
	logic  we;
	logic  sh;
	logic  ld;
	logic  init;
	row_t  init_data;
	row_t  dout;

	// model state
	row_t mem_m [MEM_DEPTH];
	row_t win_top [NUM_GENS];
	row_t win_mid [NUM_GENS];
	row_t win_bot [NUM_GENS];
	row_t res_m [NUM_GENS];
	row_t exp_dout;
	logic sh_pipe [READ_LATENCY];   // strobes in flight, index 0 newest
	logic ld_pipe [READ_LATENCY];
	row_t sh_rows [READ_LATENCY];
	row_t ld_rows [READ_LATENCY];

	row_t pat [MEM_DEPTH];          // rows written by the current test
	int   seed;
	int   cycles;
	int   checks;
	int   errors;
	int   checks_at;
	int   errors_at;

	life_row_engine dut (
		.clk       (clk),
		.reset     (reset),
		.raddr     (raddr),
		.waddr     (waddr),
		.we        (we),
		.sh        (sh),
		.ld        (ld),
		.init      (init),
		.init_data (init_data),
		.dout      (dout)
	);

	always #50 clk = ~clk;   // 100 ns period

	// run limit from the strobe count
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	// eight neighbors counted directly, columns wrap
	function automatic row_t next_gen(input row_t top, input row_t mid, input row_t bot);
		row_t rows [3];
		row_t nxt;
		int   n;
		int   col;
		rows[0] = top;
		rows[1] = mid;
		rows[2] = bot;
		for (int c = 0; c < ROW_WIDTH; c++) begin
			n = 0;
			for (int r = 0; r < 3; r++) begin
				for (int d = -1; d <= 1; d++) begin
					col = (c + d + ROW_WIDTH) % ROW_WIDTH;
					if (!(r == 1 && d == 0)) n += int'(rows[r][col]);   // skip the center
				end
			end
			nxt[c] = (n == 3) || ((n == 2) && mid[c]);
		end
		return nxt;
	endfunction

	// all stages step together from old values
	task automatic shift_model(input row_t row);
		row_t old_res [NUM_GENS];
		for (int g = 0; g < NUM_GENS; g++) old_res[g] = res_m[g];
		for (int g = 0; g < NUM_GENS; g++) begin
			res_m[g]   = next_gen(win_top[g], win_mid[g], win_bot[g]);
			win_top[g] = win_mid[g];
			win_mid[g] = win_bot[g];
			if (g == 0) begin
				win_bot[g] = row;
			end else begin
				win_bot[g] = old_res[g-1];   // previous stage, before this edge
			end
		end
	endtask

	task automatic clear_model();
		for (int g = 0; g < NUM_GENS; g++) begin
			win_top[g] = '0;
			win_mid[g] = '0;
			win_bot[g] = '0;
			res_m[g]   = '0;
		end
		for (int i = 0; i < READ_LATENCY; i++) begin
			sh_pipe[i] = 1'b0;
			ld_pipe[i] = 1'b0;
			sh_rows[i] = '0;
			ld_rows[i] = '0;
		end
		exp_dout = '0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checks and one clock of stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic check_row(input string name, input row_t exp, input row_t act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic end_test(input string name);
		$display("test %-16s %0d checks, %0d errors", name, checks - checks_at,
			errors - errors_at);
		checks_at = checks;
		errors_at = errors;
	endtask

	// drive at edge+5, model the edge, check dout at the next edge+5
	task automatic tick(input logic do_sh, input logic do_ld, input logic do_we,
		input logic do_init, input addr_t ra, input addr_t wa, input row_t data);
		row_t rd;
		row_t wr;
		sh        = do_sh;
		ld        = do_ld;
		we        = do_we;
		init      = do_init;
		raddr     = ra;
		waddr     = wa;
		init_data = data;
		@(posedge clk);
		rd = mem_m[ra];                             // same edge write not seen yet
		wr = do_init ? data : res_m[NUM_GENS-1];    // result held at this edge
		if (ld_pipe[READ_LATENCY-1]) exp_dout = ld_rows[READ_LATENCY-1];
		if (sh_pipe[READ_LATENCY-1]) shift_model(sh_rows[READ_LATENCY-1]);
		for (int i = READ_LATENCY - 1; i > 0; i--) begin
			sh_pipe[i] = sh_pipe[i-1];
			sh_rows[i] = sh_rows[i-1];
			ld_pipe[i] = ld_pipe[i-1];
			ld_rows[i] = ld_rows[i-1];
		end
		sh_pipe[0] = do_sh;
		sh_rows[0] = rd;
		ld_pipe[0] = do_ld;
		ld_rows[0] = rd;
		if (do_we) mem_m[wa] = wr;
		#5;
		check_row("dout", exp_dout, dout);
	endtask

	task automatic idle();
		tick(1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequences
	////////////////////////////////////////////////////////////////////////////

	task automatic write_rows(input int count);
		for (int k = 0; k < count; k++) tick(1'b0, 1'b0, 1'b1, 1'b1, '0, addr_t'(k), pat[k]);
		idle();   // rows settle before any read
		idle();
	endtask

	// one ld per row, dout two edges later, optionally against pat too
	task automatic load_rows(input int base, input int count, input logic vs_pat);
		for (int k = 0; k < count; k++) begin
			tick(1'b0, 1'b1, 1'b0, 1'b0, addr_t'(base + k), '0, '0);
			idle();
			idle();
			if (vs_pat) check_row("dout", pat[k], dout);
		end
	endtask

	// sh every third cycle, rows k-2 mod SRC_ROWS, results written back
	task automatic sweep_rows();
		int wa;
		for (int k = 0; k <= PUSHES; k++) begin
			wa = (k >= 8) ? DST_BASE + k - 8 : 0;   // gen NUM_GENS of row k-8 ready
			tick(k < PUSHES, 1'b0, k >= 8, 1'b0,
				addr_t'((k + SRC_ROWS - 2) % SRC_ROWS), addr_t'(wa), '0);
			idle();
			idle();
		end
	endtask

	// sh every cycle, ld with every odd sh, we every cycle once results are valid
	task automatic stream_rows();
		int wa;
		for (int k = 0; k < PUSHES + 3; k++) begin
			wa = (k >= 10) ? DST_BASE + k - 10 : 0;
			tick(k < PUSHES, (k < PUSHES) && (k % 2 == 1), k >= 10, 1'b0,
				addr_t'((k + SRC_ROWS - 2) % SRC_ROWS), addr_t'(wa), '0);
		end
		idle();
		idle();
	endtask

	task automatic random_rows(input int count);
		for (int k = 0; k < count; k++) pat[k] = {$random(seed), $random(seed)};
	endtask

	task automatic clear_rows();
		for (int k = 0; k < MEM_DEPTH; k++) pat[k] = '0;
	endtask

	initial begin
		clk       = 1'b0;
		reset     = 1'b1;
		raddr     = '0;
		waddr     = '0;
		we        = 1'b0;
		sh        = 1'b0;
		ld        = 1'b0;
		init      = 1'b0;
		init_data = '0;
		seed      = 32'hf419;
		cycles    = 0;
		checks    = 0;
		errors    = 0;
		checks_at = 0;
		errors_at = 0;
		clear_model();
		repeat (3) @(posedge clk);
		#5 reset = 1'b0;

		idle();   // dout still cleared, no ld yet
		idle();
		check_row("dout", '0, dout);
		end_test("reset");

		random_rows(MEM_DEPTH);
		write_rows(MEM_DEPTH);
		load_rows(0, MEM_DEPTH, 1'b1);
		end_test("init_load");

		random_rows(SRC_ROWS);
		write_rows(SRC_ROWS);
		sweep_rows();
		load_rows(DST_BASE, SRC_ROWS, 1'b0);
		end_test("gen_sweep");

		// blinker and glider across columns 63 and 0
		clear_rows();
		pat[4]  = row_t'(64'h8000_0000_0000_0003);
		pat[9]  = row_t'(64'h0000_0000_0000_0001);
		pat[10] = row_t'(64'h0000_0000_0000_0002);
		pat[11] = row_t'(64'h8000_0000_0000_0003);
		write_rows(SRC_ROWS);
		sweep_rows();
		load_rows(DST_BASE, SRC_ROWS, 1'b0);
		end_test("horiz_wrap");

		// still lifes and a period 2 blinker, back to the same rows
		clear_rows();
		pat[2]  = row_t'(64'h0000_0000_0030_0000);   // block at columns 20, 21
		pat[3]  = row_t'(64'h0000_0000_0030_0000);
		pat[8]  = row_t'(64'h0000_0100_0000_0000);   // vertical blinker, column 40
		pat[9]  = row_t'(64'h0000_0100_0000_0000);
		pat[10] = row_t'(64'h0000_0100_0000_0000);
		pat[12] = row_t'(64'h8000_0000_0000_0001);   // block over the edge
		pat[13] = row_t'(64'h8000_0000_0000_0001);
		write_rows(SRC_ROWS);
		sweep_rows();
		load_rows(DST_BASE, SRC_ROWS, 1'b1);
		end_test("known_patterns");

		random_rows(SRC_ROWS);
		write_rows(SRC_ROWS);
		stream_rows();
		load_rows(DST_BASE, SRC_ROWS, 1'b0);
		end_test("back_to_back");

		$display("all tests done: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* life_row_engine.f */
verilog/life_pkg.sv
verilog/life_row_ram.sv
verilog/life_read_align.sv
verilog/life_gen_stage.sv
verilog/life_row_engine.sv
verification/life_row_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the row engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f life_row_engine.f \
	--top-module life_row_engine_tb \
	-Mdir obj_dir -o sim

./obj_dir/sim > sim.log
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation failed"
	exit 1
fi

echo "simulation passed"
exit 0
